//--- all.f
hdl/mcb_pkg.sv
hdl/mem_1rw_sync.sv
hdl/mem_reg_port.sv
hdl/mc_bridge_csr.sv
hdl/dram_addr_xlate.sv
hdl/mc_bridge.sv
sim/tb_mc_bridge.sv

//--- run.sh
#!/bin/sh
# Compile and run the mc_bridge testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_mc_bridge \
  -f all.f \
  -o tb_mc_bridge

./obj_dir/tb_mc_bridge | tee sim.log

grep -q "^TESTBENCH PASSED$" sim.log

//--- sim/tb_mc_bridge.sv
`timescale 1ns/1ps

module tb_mc_bridge
  import mcb_pkg::*;
  ();

  typedef enum int {OP_WR, OP_RD, OP_BP, OP_XL, OP_CFG} op_e;

  typedef struct
  {
    string       name;
    op_e         op;
    logic [31:0] addr;
    logic [1:0]  size;
    logic [63:0] wdata;
    logic [63:0] expected; // response data, or a packed dram_pkt_t.
  } row_t;

  localparam int wait_limit = 40;
  localparam int bp_cycles  = 5;

  logic                      clk_i;
  logic                      reset_i;
  mem_header_t               mem_fwd_header_i;
  logic [dword_width-1:0]    mem_fwd_data_i;
  logic                      mem_fwd_v_i;
  logic                      mem_fwd_ready_and_o;
  mem_header_t               mem_rev_header_o;
  logic [dword_width-1:0]    mem_rev_data_o;
  logic                      mem_rev_v_o;
  logic                      mem_rev_ready_and_i;
  logic                      dram_req_v_i;
  logic [addr_width-1:0]     dram_req_addr_i;
  logic                      dram_pkt_v_o;
  dram_pkt_t                 dram_pkt_o;
  logic [pod_cord_width-1:0] dram_pod_o;
  logic [addr_width-1:0]     dram_offset_o;
  logic [cord_width-1:0]     host_cord_o;

  row_t        table_q[$];
  logic [31:0] lfsr_state = 32'hae252a92;
  int          test_errs;
  int          pass_count;
  int          fail_count;
  bit          timed_out;

  // reference model state.
  logic [31:0] m_offset;
  logic [6:0]  m_pod;
  logic [13:0] m_host;
  logic [31:0] m_spad [1024];

  mc_bridge DUT
  (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .mem_fwd_header_i    (mem_fwd_header_i),
    .mem_fwd_data_i      (mem_fwd_data_i),
    .mem_fwd_v_i         (mem_fwd_v_i),
    .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
    .mem_rev_header_o    (mem_rev_header_o),
    .mem_rev_data_o      (mem_rev_data_o),
    .mem_rev_v_o         (mem_rev_v_o),
    .mem_rev_ready_and_i (mem_rev_ready_and_i),
    .dram_req_v_i        (dram_req_v_i),
    .dram_req_addr_i     (dram_req_addr_i),
    .dram_pkt_v_o        (dram_pkt_v_o),
    .dram_pkt_o          (dram_pkt_o),
    .dram_pod_o          (dram_pod_o),
    .dram_offset_o       (dram_offset_o),
    .host_cord_o         (host_cord_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // galois form with taps of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v          = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] model_read(logic [19:0] a);
    if (a == 20'h00000)
      return {32'h0, m_offset};
    if (a == 20'h00004)
      return {57'h0, m_pod};
    if (a == 20'h00008)
      return {50'h0, m_host};
    if (a >= 20'h01000 && a < 20'h02000)
      return {32'h0, m_spad[a[11:2]]}; // index is (addr >> 2) mod 1024.
    return 64'h0;
  endfunction

  task automatic model_write(logic [19:0] a, logic [63:0] d);
    if (a == 20'h00000)
      m_offset = d[31:0];
    else if (a == 20'h00004)
      m_pod = d[6:0];
    else if (a == 20'h00008)
      m_host = d[13:0];
    else if (a >= 20'h01000 && a < 20'h02000)
      m_spad[a[11:2]] = d[31:0];
  endtask

  task automatic add_row(string name, op_e op, logic [31:0] addr, logic [63:0] wdata,
                         logic [63:0] expected);
    row_t        r;
    logic [63:0] sz;
    sz         = take_bits(2);
    r.name     = name;
    r.op       = op;
    r.addr     = addr;
    r.size     = sz[1:0];
    r.wdata    = wdata;
    r.expected = expected;
    table_q.push_back(r);
  endtask

  task automatic add_wr(string name, logic [31:0] addr, logic [63:0] wdata);
    model_write(addr[19:0], wdata);
    add_row(name, OP_WR, addr, wdata, 64'h0); // write responses carry zero.
  endtask

  task automatic add_rd(string name, logic [31:0] addr);
    add_row(name, OP_RD, addr, 64'h0, model_read(addr[19:0]));
  endtask

  task automatic add_cfg(string name);
    dram_pkt_t p;
    p = '{pod: m_pod, addr: m_offset, src: m_host};
    add_row(name, OP_CFG, 32'h0, 64'h0, 64'(p));
  endtask

  task automatic add_xl(string name, logic [31:0] addr);
    dram_pkt_t p;
    p = '{pod: m_pod, addr: m_offset + addr, src: m_host};
    add_row(name, OP_XL, addr, 64'h0, 64'(p));
  endtask

  task automatic build_table();
    logic [63:0] r;
    logic [9:0]  idx [8];
    m_offset = '0;
    m_pod    = '0;
    m_host   = '0;
    add_cfg("reset_cfg");
    add_rd("reset_rd_offset", 32'h00000);
    add_rd("reset_rd_pod", 32'h00004);
    add_rd("reset_rd_host", 32'h00008);
    add_wr("wr_offset", 32'h00000, take_bits(64));
    add_rd("rd_offset", 32'h00000);
    add_wr("wr_pod", 32'h00004, take_bits(64));
    add_rd("rd_pod", 32'h00004);
    add_wr("wr_host", 32'h00008, take_bits(64));
    add_rd("rd_host", 32'h00008);
    add_cfg("cfg_after_writes");
    for (int i = 0; i < 8; i++)
    begin
      r      = take_bits(12);
      idx[i] = r[11:2];
      // low address bits select a byte inside the same word.
      add_wr($sformatf("spad_wr%0d", i), {18'h0, 2'b01, r[11:2], r[1:0]}, take_bits(64));
    end
    for (int i = 7; i >= 0; i--)
    begin
      add_rd($sformatf("spad_rd%0d", i), {18'h0, 2'b01, idx[i], 2'b00});
    end
    add_wr("spad_wr_top", 32'h01ffe, take_bits(64));
    add_rd("spad_rd_top", 32'h01ffc);
    add_rd("unmapped_rd_0c", 32'h0000c);
    add_rd("unmapped_rd_2000", 32'h02000);
    add_wr("unmapped_wr_10", 32'h00010, take_bits(64));
    add_wr("unmapped_wr_02", 32'h00002, take_bits(64));
    add_cfg("cfg_after_unmapped");
    add_rd("rd_offset_again", 32'h00000);
    add_row("bp_rd_host", OP_BP, 32'h00008, 64'h0, model_read(20'h00008));
    for (int i = 0; i < 4; i++)
    begin
      add_xl($sformatf("xlate%0d", i), 32'(take_bits(32)));
    end
    add_wr("wr_offset_high", 32'h00000, 64'h0000_0000_ffff_ff00);
    add_xl("xlate_wrap", 32'h00000200);
    add_xl("xlate_zero", 32'h00000000);
  endtask

  task automatic report_timeout(string what);
    $display("timeout while waiting for %s", what);
    test_errs++;
    timed_out = 1'b1;
  endtask

  task automatic check_resp(string name, mem_header_t exp_hdr, logic [63:0] exp_data,
                            mem_header_t act_hdr, logic [63:0] act_data);
    if (act_hdr !== exp_hdr)
    begin
      $display("error %s header: expected %h actual %h", name, exp_hdr, act_hdr);
      test_errs++;
    end
    if (act_data !== exp_data)
    begin
      $display("error %s data: expected %h actual %h", name, exp_data, act_data);
      test_errs++;
    end
  endtask

  task automatic check_pkt(string name, dram_pkt_t exp_pkt, dram_pkt_t act_pkt);
    if (act_pkt !== exp_pkt)
    begin
      $display("error %s: expected %h actual %h", name, exp_pkt, act_pkt);
      test_errs++;
    end
  endtask

  task automatic mem_request(mem_header_t hdr, logic [63:0] data, bit hold,
                             output mem_header_t rsp_hdr, output logic [63:0] rsp_data);
    int cnt;
    rsp_hdr  = '0;
    rsp_data = '0;
    cnt      = 0;
    while (!mem_fwd_ready_and_o && cnt < wait_limit)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (!mem_fwd_ready_and_o)
    begin
      report_timeout("mem_fwd_ready_and_o");
      return;
    end
    mem_fwd_header_i    = hdr;
    mem_fwd_data_i      = data;
    mem_fwd_v_i         = 1'b1;
    mem_rev_ready_and_i = !hold;
    @(negedge clk_i);
    mem_fwd_v_i = 1'b0;
    cnt = 0;
    while (!mem_rev_v_o && cnt < wait_limit)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (!mem_rev_v_o)
    begin
      mem_rev_ready_and_i = 1'b1;
      report_timeout("mem_rev_v_o");
      return;
    end
    rsp_hdr  = mem_rev_header_o;
    rsp_data = mem_rev_data_o;
    if (hold)
    begin
      for (int i = 0; i < bp_cycles; i++)
      begin
        @(negedge clk_i);
        if (!mem_rev_v_o)
        begin
          $display("response valid dropped while the reverse port was stalled");
          test_errs++;
        end
        if (mem_rev_header_o !== rsp_hdr || mem_rev_data_o !== rsp_data)
        begin
          $display("response contents changed while the reverse port was stalled");
          test_errs++;
        end
        if (mem_fwd_ready_and_o)
        begin
          $display("forward ready was high while a response was pending");
          test_errs++;
        end
      end
      mem_rev_ready_and_i = 1'b1;
      @(negedge clk_i);
      if (mem_rev_v_o || !mem_fwd_ready_and_o)
      begin
        $display("response was not released after the stall ended");
        test_errs++;
      end
    end
  endtask

  task automatic translate(logic [31:0] addr, output dram_pkt_t pkt);
    dram_req_v_i    = 1'b1;
    dram_req_addr_i = addr;
    @(negedge clk_i);
    dram_req_v_i = 1'b0;
    if (dram_pkt_v_o !== 1'b1)
    begin
      $display("packet valid was not high one cycle after the request");
      test_errs++;
    end
    pkt = dram_pkt_o;
    @(negedge clk_i);
    if (dram_pkt_v_o !== 1'b0)
    begin
      $display("packet valid stayed high after a single request");
      test_errs++;
    end
  endtask

  initial
  begin
    row_t        row;
    mem_header_t hdr;
    mem_header_t rsp_hdr;
    logic [63:0] rsp_data;
    dram_pkt_t   pkt;
    reset_i             = 1'b1;
    mem_fwd_header_i    = '0;
    mem_fwd_data_i      = '0;
    mem_fwd_v_i         = 1'b0;
    mem_rev_ready_and_i = 1'b1;
    dram_req_v_i        = 1'b0;
    dram_req_addr_i     = '0;
    pass_count          = 0;
    fail_count          = 0;
    timed_out           = 1'b0;
    build_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    for (int i = 0; i < table_q.size() && !timed_out; i++)
    begin
      row       = table_q[i];
      test_errs = 0;
      case (row.op)
        OP_WR, OP_RD, OP_BP:
        begin
          hdr.msg_type = (row.op == OP_WR) ? e_mem_wr : e_mem_rd;
          hdr.addr     = row.addr[19:0];
          hdr.size     = row.size;
          mem_request(hdr, row.wdata, row.op == OP_BP, rsp_hdr, rsp_data);
          if (!timed_out)
            check_resp(row.name, hdr, row.expected, rsp_hdr, rsp_data);
        end
        OP_XL:
        begin
          translate(row.addr, pkt);
          check_pkt(row.name, row.expected[52:0], pkt);
        end
        default:
        begin
          @(negedge clk_i);
          pkt = '{pod: dram_pod_o, addr: dram_offset_o, src: host_cord_o};
          check_pkt(row.name, row.expected[52:0], pkt);
        end
      endcase
      if (test_errs == 0)
      begin
        $display("ok   %s", row.name);
        pass_count++;
      end
      else
      begin
        $display("fail %s", row.name);
        fail_count++;
      end
    end
    $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- hdl/mc_bridge.sv
`timescale 1ns/1ps

module mc_bridge
  import mcb_pkg::*;
  (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  mem_header_t               mem_fwd_header_i,
    input  logic [dword_width-1:0]    mem_fwd_data_i,
    input  logic                      mem_fwd_v_i,
    output logic                      mem_fwd_ready_and_o,

    output mem_header_t               mem_rev_header_o,
    output logic [dword_width-1:0]    mem_rev_data_o,
    output logic                      mem_rev_v_o,
    input  logic                      mem_rev_ready_and_i,

    input  logic                      dram_req_v_i,
    input  logic [addr_width-1:0]     dram_req_addr_i,
    output logic                      dram_pkt_v_o,
    output dram_pkt_t                 dram_pkt_o,

    output logic [pod_cord_width-1:0] dram_pod_o,
    output logic [addr_width-1:0]     dram_offset_o,
    output logic [cord_width-1:0]     host_cord_o
  );

  mc_bridge_csr csr
  (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .mem_fwd_header_i    (mem_fwd_header_i),
    .mem_fwd_data_i      (mem_fwd_data_i),
    .mem_fwd_v_i         (mem_fwd_v_i),
    .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
    .mem_rev_header_o    (mem_rev_header_o),
    .mem_rev_data_o      (mem_rev_data_o),
    .mem_rev_v_o         (mem_rev_v_o),
    .mem_rev_ready_and_i (mem_rev_ready_and_i),
    .dram_pod_o          (dram_pod_o),
    .dram_offset_o       (dram_offset_o),
    .host_cord_o         (host_cord_o)
  );

  // config outputs also steer the translator.
  dram_addr_xlate xlate
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .dram_req_v_i    (dram_req_v_i),
    .dram_req_addr_i (dram_req_addr_i),
    .dram_pod_i      (dram_pod_o),
    .dram_offset_i   (dram_offset_o),
    .host_cord_i     (host_cord_o),
    .dram_pkt_v_o    (dram_pkt_v_o),
    .dram_pkt_o      (dram_pkt_o)
  );

endmodule

//--- hdl/dram_addr_xlate.sv
`timescale 1ns/1ps

module dram_addr_xlate
  import mcb_pkg::*;
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      dram_req_v_i,
    input  logic [addr_width-1:0]     dram_req_addr_i,
    input  logic [pod_cord_width-1:0] dram_pod_i,
    input  logic [addr_width-1:0]     dram_offset_i,
    input  logic [cord_width-1:0]     host_cord_i,
    output logic                      dram_pkt_v_o,
    output dram_pkt_t                 dram_pkt_o
  );

  dram_pkt_t pkt_n;
  dram_pkt_t pkt_r;
  logic      pkt_v_r;

  always_comb
  begin
    pkt_n.pod  = dram_pod_i;
    pkt_n.addr = dram_offset_i + dram_req_addr_i; // wraps at 2**32.
    pkt_n.src  = host_cord_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pkt_v_r <= 1'b0;
    else
      pkt_v_r <= dram_req_v_i;
  end

  // config is sampled with the request.
  always_ff @(posedge clk_i)
  begin
    if (dram_req_v_i)
      pkt_r <= pkt_n;
  end

  assign dram_pkt_v_o = pkt_v_r;
  assign dram_pkt_o   = pkt_r;

endmodule

//--- hdl/mc_bridge_csr.sv
`timescale 1ns/1ps

module mc_bridge_csr
  import mcb_pkg::*;
  (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  mem_header_t               mem_fwd_header_i,
    input  logic [dword_width-1:0]    mem_fwd_data_i,
    input  logic                      mem_fwd_v_i,
    output logic                      mem_fwd_ready_and_o,

    output mem_header_t               mem_rev_header_o,
    output logic [dword_width-1:0]    mem_rev_data_o,
    output logic                      mem_rev_v_o,
    input  logic                      mem_rev_ready_and_i,

    output logic [pod_cord_width-1:0] dram_pod_o,
    output logic [addr_width-1:0]     dram_offset_o,
    output logic [cord_width-1:0]     host_cord_o
  );

  logic [reg_els-1:0]                  r_v_lo;
  logic [reg_els-1:0]                  w_v_lo;
  logic [dev_addr_width-1:0]           addr_lo;
  logic [dword_width-1:0]              data_lo;
  logic [reg_els-1:0][dword_width-1:0] data_li;

  logic [addr_width-1:0]               dram_offset_r;
  logic [pod_cord_width-1:0]           dram_pod_r;
  logic [cord_width-1:0]               host_cord_r;

  logic [spad_addr_width-1:0]          spad_addr;
  logic [spad_width-1:0]               spad_data_lo;

  mem_reg_port port
  (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .mem_fwd_header_i    (mem_fwd_header_i),
    .mem_fwd_data_i      (mem_fwd_data_i),
    .mem_fwd_v_i         (mem_fwd_v_i),
    .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
    .mem_rev_header_o    (mem_rev_header_o),
    .mem_rev_data_o      (mem_rev_data_o),
    .mem_rev_v_o         (mem_rev_v_o),
    .mem_rev_ready_and_i (mem_rev_ready_and_i),
    .r_v_o               (r_v_lo),
    .w_v_o               (w_v_lo),
    .addr_o              (addr_lo),
    .data_o              (data_lo),
    .data_i              (data_li)
  );

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      dram_offset_r <= '0;
      dram_pod_r    <= '0;
      host_cord_r   <= '0;
    end
    else
    begin
      if (w_v_lo[el_dram_offset])
        dram_offset_r <= data_lo[addr_width-1:0];
      if (w_v_lo[el_dram_pod])
        dram_pod_r <= data_lo[pod_cord_width-1:0];
      if (w_v_lo[el_host_cord])
        host_cord_r <= data_lo[cord_width-1:0];
    end
  end

  // word index wraps modulo spad_els.
  assign spad_addr = spad_addr_width'(addr_lo >> $clog2(spad_width / 8));

  mem_1rw_sync scratchpad
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (r_v_lo[el_spad] | w_v_lo[el_spad]),
    .w_i     (w_v_lo[el_spad]),
    .addr_i  (spad_addr),
    .data_i  (data_lo[spad_width-1:0]), // low 32 bits only.
    .data_o  (spad_data_lo)
  );

  assign data_li[el_dram_offset] = dword_width'(dram_offset_r);
  assign data_li[el_dram_pod]    = dword_width'(dram_pod_r);
  assign data_li[el_host_cord]   = dword_width'(host_cord_r);
  assign data_li[el_spad]        = dword_width'(spad_data_lo);

  assign dram_offset_o = dram_offset_r;
  assign dram_pod_o    = dram_pod_r;
  assign host_cord_o   = host_cord_r;

  a_spad_rw_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(r_v_lo[el_spad] && w_v_lo[el_spad]));

endmodule

//--- hdl/mem_reg_port.sv
`timescale 1ns/1ps

module mem_reg_port
  import mcb_pkg::*;
  (
    input  logic                                clk_i,
    input  logic                                reset_i,

    input  mem_header_t                         mem_fwd_header_i,
    input  logic [dword_width-1:0]              mem_fwd_data_i,
    input  logic                                mem_fwd_v_i,
    output logic                                mem_fwd_ready_and_o,

    output mem_header_t                         mem_rev_header_o,
    output logic [dword_width-1:0]              mem_rev_data_o,
    output logic                                mem_rev_v_o,
    input  logic                                mem_rev_ready_and_i,

    output logic [reg_els-1:0]                  r_v_o,
    output logic [reg_els-1:0]                  w_v_o,
    output logic [dev_addr_width-1:0]           addr_o,
    output logic [dword_width-1:0]              data_o,
    input  logic [reg_els-1:0][dword_width-1:0] data_i
  );

  logic [reg_els-1:0]     sel;
  logic                   accept;
  logic                   pending_r;
  logic                   capture_r;
  logic [reg_els-1:0]     rd_sel_r;
  mem_header_t            header_r;
  logic [dword_width-1:0] data_r;
  logic [dword_width-1:0] rd_data;

  always_comb
  begin
    sel                 = '0;
    sel[el_dram_offset] = (mem_fwd_header_i.addr == reg_dram_offset_addr);
    sel[el_dram_pod]    = (mem_fwd_header_i.addr == reg_dram_pod_addr);
    sel[el_host_cord]   = (mem_fwd_header_i.addr == reg_host_cord_addr);
    sel[el_spad]        = (mem_fwd_header_i.addr >= spad_base_addr)
                       && (mem_fwd_header_i.addr < spad_end_addr);
  end

  assign mem_fwd_ready_and_o = ~pending_r; // one request in flight.
  assign accept              = mem_fwd_v_i & mem_fwd_ready_and_o;

  assign r_v_o  = (accept && mem_fwd_header_i.msg_type == e_mem_rd) ? sel : '0;
  assign w_v_o  = (accept && mem_fwd_header_i.msg_type == e_mem_wr) ? sel : '0;
  assign addr_o = mem_fwd_header_i.addr;
  assign data_o = mem_fwd_data_i;

  // writes and unmapped reads leave rd_sel_r empty, so the data is zero.
  always_comb
  begin
    rd_data = '0;
    for (int k = 0; k < reg_els; k++)
    begin
      rd_data = rd_data | (data_i[k] & {dword_width{rd_sel_r[k]}});
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pending_r <= 1'b0;
      capture_r <= 1'b0;
    end
    else
    begin
      if (accept)
        pending_r <= 1'b1;
      else if (mem_rev_ready_and_i)
        pending_r <= 1'b0;
      capture_r <= accept; // first response cycle.
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      header_r <= mem_fwd_header_i;
      rd_sel_r <= r_v_o;
    end
    if (capture_r)
      data_r <= rd_data; // held across back-pressure.
  end

  assign mem_rev_v_o      = pending_r;
  assign mem_rev_header_o = header_r;
  assign mem_rev_data_o   = capture_r ? rd_data : data_r;

  a_strobe_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({r_v_o, w_v_o}));

  a_rev_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_rev_v_o && !mem_rev_ready_and_i |=>
      mem_rev_v_o && $stable(mem_rev_header_o) && $stable(mem_rev_data_o));

endmodule

//--- hdl/mem_1rw_sync.sv
`timescale 1ns/1ps

module mem_1rw_sync
  import mcb_pkg::*;
  (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       v_i,
    input  logic                       w_i,
    input  logic [spad_addr_width-1:0] addr_i,
    input  logic [spad_width-1:0]      data_i,
    output logic [spad_width-1:0]      data_o
  );

  logic [spad_width-1:0] mem [spad_els];
  logic [spad_width-1:0] data_r;
  logic                  en;

  assign en = v_i & ~reset_i; // no access while in reset.

  always_ff @(posedge clk_i)
  begin
    if (en && w_i)
      mem[addr_i] <= data_i;
  end

  // read data stays until the next read.
  always_ff @(posedge clk_i)
  begin
    if (en && !w_i)
      data_r <= mem[addr_i];
  end

  assign data_o = data_r;

endmodule

//--- hdl/mcb_pkg.sv
package mcb_pkg;

  localparam int dword_width      = 64;
  localparam int dev_addr_width   = 20;
  localparam int addr_width       = 32;

  localparam int x_cord_width     = 7;
  localparam int y_cord_width     = 7;
  localparam int cord_width       = x_cord_width + y_cord_width;
  localparam int pod_x_cord_width = 3;
  localparam int pod_y_cord_width = 4;
  localparam int pod_cord_width   = pod_x_cord_width + pod_y_cord_width;

  localparam int spad_width       = 32;
  localparam int spad_els         = 1024;
  localparam int spad_addr_width  = $clog2(spad_els);
  localparam int spad_bytes       = spad_els * (spad_width / 8);

  // element order on the register port strobes.
  localparam int reg_els          = 4;
  localparam int el_dram_offset   = 0;
  localparam int el_dram_pod      = 1;
  localparam int el_host_cord     = 2;
  localparam int el_spad          = 3;

  localparam logic [dev_addr_width-1:0] reg_dram_offset_addr = 20'h0_0000;
  localparam logic [dev_addr_width-1:0] reg_dram_pod_addr    = 20'h0_0004;
  localparam logic [dev_addr_width-1:0] reg_host_cord_addr   = 20'h0_0008;
  localparam logic [dev_addr_width-1:0] spad_base_addr       = 20'h0_1000;
  localparam logic [dev_addr_width-1:0] spad_end_addr        =
    spad_base_addr + dev_addr_width'(spad_bytes); // first address past the scratchpad.

  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_msg_e;

  typedef struct packed
  {
    mem_msg_e                  msg_type;
    logic [dev_addr_width-1:0] addr;
    logic [1:0]                size;     // carried through, never decoded.
  } mem_header_t;

  typedef struct packed
  {
    logic [pod_cord_width-1:0] pod;
    logic [addr_width-1:0]     addr;
    logic [cord_width-1:0]     src;
  } dram_pkt_t;

endpackage
